//--- source/exec_pkg.sv
/*
 * Execution back end shared definitions.
 * Widths, ID type, opcodes and writeback unit ordering.
 */
`default_nettype none

package exec_pkg;

    ////////////////////
    // Widths and counts

    localparam int XLEN = 32;
    localparam int ID_WIDTH = 3;

    // Iterations of the restoring divider, one per quotient bit
    localparam int DIV_CYCLES = 32;

    // Units sharing the writeback port
    localparam int NUM_UNITS = 3;

    ////////////////////
    // Types

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ID_WIDTH-1:0] id_t;

    // Issue opcodes
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLT   = 4'd5,
        OP_SLTU  = 4'd6,
        OP_SLL   = 4'd7,
        OP_SRL   = 4'd8,
        OP_SRA   = 4'd9,
        // Multiplier
        OP_MUL   = 4'd10,
        OP_MULHU = 4'd11,
        // Divider
        OP_DIVU  = 4'd12,
        OP_REMU  = 4'd13
    } exec_op_t;

    // Writeback units, lowest value wins arbitration
    typedef enum logic [1:0] {
        UNIT_ALU = 2'd0,
        UNIT_MUL = 2'd1,
        UNIT_DIV = 2'd2
    } unit_id_t;

endpackage

`default_nettype wire

//--- source/alu_unit.sv
/*
 * Single-cycle integer ALU.
 * Result and ID are registered and held until the writeback ack.
 */
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             new_request,
    input  exec_pkg::exec_op_t    op,
    input  exec_pkg::xlen_t       rs1,
    input  exec_pkg::xlen_t       rs2,
    input  exec_pkg::id_t         id,
    input  wire logic             ack,
    output logic                  ready,
    output logic                  done,
    output exec_pkg::xlen_t       result,
    output exec_pkg::id_t         result_id
);

    logic [$clog2(exec_pkg::XLEN)-1:0] shamt;
    exec_pkg::xlen_t alu_out;

    assign shamt = rs2[$clog2(exec_pkg::XLEN)-1:0];

    always_comb begin
        case (op)
            exec_pkg::OP_ADD:  alu_out = rs1 + rs2;
            exec_pkg::OP_SUB:  alu_out = rs1 - rs2;
            exec_pkg::OP_AND:  alu_out = rs1 & rs2;
            exec_pkg::OP_OR:   alu_out = rs1 | rs2;
            exec_pkg::OP_XOR:  alu_out = rs1 ^ rs2;
            exec_pkg::OP_SLT:  alu_out = exec_pkg::xlen_t'($signed(rs1) < $signed(rs2));
            exec_pkg::OP_SLTU: alu_out = exec_pkg::xlen_t'(rs1 < rs2);
            exec_pkg::OP_SLL:  alu_out = rs1 << shamt;
            exec_pkg::OP_SRL:  alu_out = rs1 >> shamt;
            exec_pkg::OP_SRA:  alu_out = $signed(rs1) >>> shamt;
            default:           alu_out = '0;
        endcase
    end

    // Free again in the cycle the held result is taken
    assign ready = !done || ack;

    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else if (new_request) begin
            done <= 1'b1;
        end else if (ack) begin
            done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (new_request) begin
            result <= alu_out;
            result_id <= id;
        end
    end

endmodule

`default_nettype wire

//--- source/mul_unit.sv
/*
 * Two-stage pipelined 32x32 unsigned multiplier.
 * Gives the low product word for MUL or the high word for MULHU.
 */
`timescale 1ns/1ps
`default_nettype none

module mul_unit (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             new_request,
    input  exec_pkg::exec_op_t    op,
    input  exec_pkg::xlen_t       rs1,
    input  exec_pkg::xlen_t       rs2,
    input  exec_pkg::id_t         id,
    input  wire logic             ack,
    output logic                  ready,
    output logic                  done,
    output exec_pkg::xlen_t       result,
    output exec_pkg::id_t         result_id
);

    localparam int W = exec_pkg::XLEN;

    // Stage one holds operands
    logic s1_valid;
    exec_pkg::xlen_t s1_rs1;
    exec_pkg::xlen_t s1_rs2;
    logic s1_high;
    exec_pkg::id_t s1_id;

    // Stage two holds the product, done is its valid
    logic [2*W-1:0] product_d;
    logic [2*W-1:0] product_q;
    logic s2_high;
    logic s2_advance;

    assign product_d = {{W{1'b0}}, s1_rs1} * {{W{1'b0}}, s1_rs2};

    // Stage two moves unless it holds an unacked result
    assign s2_advance = !done || ack;
    assign ready = !s1_valid || s2_advance;

    assign result = s2_high ? product_q[2*W-1:W] : product_q[W-1:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            done <= 1'b0;
        end else begin
            if (s2_advance)
                done <= s1_valid;
            if (new_request)
                s1_valid <= 1'b1;
            else if (s2_advance)
                s1_valid <= 1'b0;
        end
    end

    ////////////////////
    // Payload

    always_ff @(posedge clk) begin
        if (new_request) begin
            s1_rs1 <= rs1;
            s1_rs2 <= rs2;
            s1_high <= (op == exec_pkg::OP_MULHU);
            s1_id <= id;
        end
        if (s2_advance && s1_valid) begin
            product_q <= product_d;
            s2_high <= s1_high;
            result_id <= s1_id;
        end
    end

    // A held result must stay until the arbiter takes it
    done_held_until_ack : assert property (
        @(posedge clk) disable iff (reset) (done && !ack) |=> done
    ) else $error("mul_unit dropped done without ack");

endmodule

`default_nettype wire

//--- source/div_unit.sv
/*
 * Iterative restoring unsigned divider.
 * One quotient bit per cycle, quotient for DIVU or remainder for REMU.
 */
`timescale 1ns/1ps
`default_nettype none

module div_unit (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             new_request,
    input  exec_pkg::exec_op_t    op,
    input  exec_pkg::xlen_t       rs1,
    input  exec_pkg::xlen_t       rs2,
    input  exec_pkg::id_t         id,
    input  wire logic             ack,
    output logic                  ready,
    output logic                  done,
    output exec_pkg::xlen_t       result,
    output exec_pkg::id_t         result_id
);

    localparam int W = exec_pkg::XLEN;

    typedef logic [$clog2(exec_pkg::DIV_CYCLES)-1:0] count_t;

    logic busy;
    logic last;
    count_t count;
    logic is_rem;
    exec_pkg::xlen_t quotient;
    exec_pkg::xlen_t remainder;
    exec_pkg::xlen_t divisor;
    logic [W:0] shifted;
    logic [W+1:0] trial;

    // Shift in the next dividend bit and try the subtraction
    assign shifted = {remainder, quotient[W-1]};
    assign trial = {1'b0, shifted} - {2'b00, divisor};

    assign last = (count == count_t'(exec_pkg::DIV_CYCLES - 1));
    assign ready = !busy && (!done || ack);
    assign result = is_rem ? remainder : quotient;

    ////////////////////
    // Control

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end else if (new_request) begin
            busy <= 1'b1;
            done <= 1'b0;
            count <= '0;
        end else if (busy) begin
            count <= count + count_t'(1);
            if (last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end else if (ack) begin
            done <= 1'b0;
        end
    end

    ////////////////////
    // Datapath

    // Zero divisor always subtracts, giving all ones and the dividend
    always_ff @(posedge clk) begin
        if (new_request) begin
            quotient <= rs1;
            remainder <= '0;
            divisor <= rs2;
            is_rem <= (op == exec_pkg::OP_REMU);
            result_id <= id;
        end else if (busy) begin
            quotient <= {quotient[W-2:0], ~trial[W+1]};
            remainder <= trial[W+1] ? shifted[W-1:0] : trial[W-1:0];
        end
    end

    // Issue must wait for the previous result to be taken
    no_request_while_busy : assert property (
        @(posedge clk) disable iff (reset) new_request |-> !busy
    ) else $error("div_unit got a request while busy");

endmodule

`default_nettype wire

//--- source/writeback_arbiter.sv
/*
 * Fixed-priority writeback arbiter.
 * Grants the first finished unit in ALU, MUL, DIV order.
 */
`timescale 1ns/1ps
`default_nettype none

module writeback_arbiter (
    input  wire logic [exec_pkg::NUM_UNITS-1:0] unit_done,
    input  exec_pkg::xlen_t                     alu_result,
    input  exec_pkg::xlen_t                     mul_result,
    input  exec_pkg::xlen_t                     div_result,
    input  exec_pkg::id_t                       alu_id,
    input  exec_pkg::id_t                       mul_id,
    input  exec_pkg::id_t                       div_id,
    output logic [exec_pkg::NUM_UNITS-1:0]      unit_ack,
    output logic                                wb_valid,
    output exec_pkg::id_t                       wb_id,
    output exec_pkg::xlen_t                     wb_data
);

    // Some unit always wins when any is done
    assign wb_valid = |unit_done;

    always_comb begin
        unit_ack = '0;
        wb_id = '0;
        wb_data = '0;
        if (unit_done[exec_pkg::UNIT_ALU]) begin
            unit_ack[exec_pkg::UNIT_ALU] = 1'b1;
            wb_id = alu_id;
            wb_data = alu_result;
        end else if (unit_done[exec_pkg::UNIT_MUL]) begin
            unit_ack[exec_pkg::UNIT_MUL] = 1'b1;
            wb_id = mul_id;
            wb_data = mul_result;
        end else if (unit_done[exec_pkg::UNIT_DIV]) begin
            unit_ack[exec_pkg::UNIT_DIV] = 1'b1;
            wb_id = div_id;
            wb_data = div_result;
        end
    end

    // At most one grant, and only to a unit holding a result
    always_comb begin
        ack_legal : assert final (
            $onehot0(unit_ack) && ((unit_ack & ~unit_done) == '0)
        ) else $error("writeback_arbiter granted an illegal ack");
    end

endmodule

`default_nettype wire

//--- source/exec_core.sv
/*
 * Execution back end top level.
 * Dispatches issued ops by opcode to ALU, MUL or DIV
 * and merges their results onto one writeback port.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_core (
    input  wire logic             clk,
    input  wire logic             reset,
    input  wire logic             issue_valid,
    input  exec_pkg::exec_op_t    issue_op,
    input  exec_pkg::xlen_t       issue_rs1,
    input  exec_pkg::xlen_t       issue_rs2,
    input  exec_pkg::id_t         issue_id,
    output logic                  issue_ready,
    output logic                  wb_valid,
    output exec_pkg::id_t         wb_id,
    output exec_pkg::xlen_t       wb_data
);

    exec_pkg::unit_id_t issue_unit;
    logic issue_accept;
    logic [exec_pkg::NUM_UNITS-1:0] unit_request;
    logic [exec_pkg::NUM_UNITS-1:0] unit_ready;
    logic [exec_pkg::NUM_UNITS-1:0] unit_done;
    logic [exec_pkg::NUM_UNITS-1:0] unit_ack;
    exec_pkg::xlen_t alu_result, mul_result, div_result;
    exec_pkg::id_t alu_id, mul_id, div_id;

    ////////////////////
    // Dispatch

    always_comb begin
        case (issue_op)
            exec_pkg::OP_MUL, exec_pkg::OP_MULHU: issue_unit = exec_pkg::UNIT_MUL;
            exec_pkg::OP_DIVU, exec_pkg::OP_REMU: issue_unit = exec_pkg::UNIT_DIV;
            default:                              issue_unit = exec_pkg::UNIT_ALU;
        endcase
    end

    assign issue_ready = unit_ready[issue_unit];
    assign issue_accept = issue_valid && issue_ready;

    always_comb begin
        for (int i = 0; i < exec_pkg::NUM_UNITS; i++)
            unit_request[i] = issue_accept && (issue_unit == exec_pkg::unit_id_t'(i));
    end

    ////////////////////
    // Units

    alu_unit u_alu (
        .clk(clk), .reset(reset), .new_request(unit_request[exec_pkg::UNIT_ALU]),
        .op(issue_op), .rs1(issue_rs1), .rs2(issue_rs2), .id(issue_id),
        .ack(unit_ack[exec_pkg::UNIT_ALU]), .ready(unit_ready[exec_pkg::UNIT_ALU]),
        .done(unit_done[exec_pkg::UNIT_ALU]), .result(alu_result), .result_id(alu_id)
    );

    mul_unit u_mul (
        .clk(clk), .reset(reset), .new_request(unit_request[exec_pkg::UNIT_MUL]),
        .op(issue_op), .rs1(issue_rs1), .rs2(issue_rs2), .id(issue_id),
        .ack(unit_ack[exec_pkg::UNIT_MUL]), .ready(unit_ready[exec_pkg::UNIT_MUL]),
        .done(unit_done[exec_pkg::UNIT_MUL]), .result(mul_result), .result_id(mul_id)
    );

    div_unit u_div (
        .clk(clk), .reset(reset), .new_request(unit_request[exec_pkg::UNIT_DIV]),
        .op(issue_op), .rs1(issue_rs1), .rs2(issue_rs2), .id(issue_id),
        .ack(unit_ack[exec_pkg::UNIT_DIV]), .ready(unit_ready[exec_pkg::UNIT_DIV]),
        .done(unit_done[exec_pkg::UNIT_DIV]), .result(div_result), .result_id(div_id)
    );

    writeback_arbiter u_wb_arb (
        .unit_done(unit_done), .alu_result(alu_result), .mul_result(mul_result),
        .div_result(div_result), .alu_id(alu_id), .mul_id(mul_id), .div_id(div_id),
        .unit_ack(unit_ack), .wb_valid(wb_valid), .wb_id(wb_id), .wb_data(wb_data)
    );

    // Units only ever see requests they can take
    request_only_when_ready : assert property (
        @(posedge clk) disable iff (reset) (unit_request & ~unit_ready) == '0
    ) else $error("exec_core sent a request to a busy unit");

endmodule

`default_nettype wire

//--- dv/exec_core_tb.sv
/*
 * Testbench for the execution back end.
 * Walks a table of ops through the issue port and scores the writeback port.
 */
`timescale 1ns/1ps
`default_nettype none

module exec_core_tb;

    localparam int HALF_PERIOD = 20;
    localparam int NUM_ROWS = 27;
    localparam int NUM_IDS = 8;
    localparam int TIMEOUT_CYCLES = 200;
    localparam int DIVU_ROW = 20;
    localparam int ALU_AFTER_DIVU_ROW = 21;

    logic clk;
    logic reset;
    logic issue_valid;
    exec_pkg::exec_op_t issue_op;
    exec_pkg::xlen_t issue_rs1;
    exec_pkg::xlen_t issue_rs2;
    exec_pkg::id_t issue_id;
    logic issue_ready;
    logic wb_valid;
    exec_pkg::id_t wb_id;
    exec_pkg::xlen_t wb_data;

    // Stimulus table, one op per row
    exec_pkg::exec_op_t tbl_op [NUM_ROWS];
    exec_pkg::xlen_t tbl_rs1 [NUM_ROWS];
    exec_pkg::xlen_t tbl_rs2 [NUM_ROWS];
    exec_pkg::xlen_t tbl_exp [NUM_ROWS];
    int num_filled;

    // Scoreboard indexed by ID and by row
    logic outstanding [NUM_IDS];
    int row_of_id [NUM_IDS];
    int done_order [NUM_ROWS];
    int num_done;

    exec_core u_exec_core (
        .clk(clk), .reset(reset), .issue_valid(issue_valid), .issue_op(issue_op),
        .issue_rs1(issue_rs1), .issue_rs2(issue_rs2), .issue_id(issue_id),
        .issue_ready(issue_ready), .wb_valid(wb_valid), .wb_id(wb_id), .wb_data(wb_data)
    );

    initial clk = 1'b0;
    always #HALF_PERIOD clk = ~clk;

    ////////////////////
    // Checks

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input exec_pkg::xlen_t got,
                              input exec_pkg::xlen_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_id(input string name, input exec_pkg::id_t got,
                            input exec_pkg::id_t exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    ////////////////////
    // Expected ordering

    // Unit each opcode class is dispatched to
    function automatic exec_pkg::unit_id_t unit_of_op(input exec_pkg::exec_op_t op);
        if (op == exec_pkg::OP_MUL || op == exec_pkg::OP_MULHU)
            return exec_pkg::UNIT_MUL;
        if (op == exec_pkg::OP_DIVU || op == exec_pkg::OP_REMU)
            return exec_pkg::UNIT_DIV;
        return exec_pkg::UNIT_ALU;
    endfunction

    // Units write back in issue order so the oldest pending op is next
    function automatic exec_pkg::id_t oldest_pending_id(input exec_pkg::unit_id_t unit);
        int oldest_row;
        exec_pkg::id_t oldest_id;
        oldest_row = NUM_ROWS;
        oldest_id = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            if (outstanding[i] && unit_of_op(tbl_op[row_of_id[i]]) == unit &&
                    row_of_id[i] < oldest_row) begin
                oldest_row = row_of_id[i];
                oldest_id = exec_pkg::id_t'(i);
            end
        end
        return oldest_id;
    endfunction

    ////////////////////
    // Stimulus table

    task automatic add_row(input exec_pkg::exec_op_t op, input exec_pkg::xlen_t a,
                           input exec_pkg::xlen_t b, input exec_pkg::xlen_t exp);
        tbl_op[num_filled] = op;
        tbl_rs1[num_filled] = a;
        tbl_rs2[num_filled] = b;
        tbl_exp[num_filled] = exp;
        num_filled++;
    endtask

    task automatic build_table();
        exec_pkg::xlen_t a;
        exec_pkg::xlen_t b;
        num_filled = 0;
        add_row(exec_pkg::OP_ADD, 32'd5, 32'd7, 32'h0000_000c);
        add_row(exec_pkg::OP_SUB, 32'd3, 32'd5, 32'hffff_fffe);
        add_row(exec_pkg::OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hf000_f000);
        add_row(exec_pkg::OP_OR, 32'hf0f0_f0f0, 32'hff00_ff00, 32'hfff0_fff0);
        add_row(exec_pkg::OP_XOR, 32'hf0f0_f0f0, 32'hff00_ff00, 32'h0ff0_0ff0);
        // -1 < 1 only when signed
        add_row(exec_pkg::OP_SLT, 32'hffff_ffff, 32'd1, 32'd1);
        add_row(exec_pkg::OP_SLTU, 32'hffff_ffff, 32'd1, 32'd0);
        add_row(exec_pkg::OP_SLL, 32'd1, 32'd31, 32'h8000_0000);
        add_row(exec_pkg::OP_SRL, 32'h8000_0000, 32'd4, 32'h0800_0000);
        add_row(exec_pkg::OP_SRA, 32'h8000_0000, 32'd4, 32'hf800_0000);
        // Shift amount uses the low five bits only
        add_row(exec_pkg::OP_SRA, 32'hffff_ff00, 32'd36, 32'hffff_fff0);
        // Back-to-back multiplies
        add_row(exec_pkg::OP_MUL, 32'h0001_0000, 32'h0001_0000, 32'h0000_0000);
        add_row(exec_pkg::OP_MULHU, 32'hffff_ffff, 32'hffff_ffff, 32'hffff_fffe);
        add_row(exec_pkg::OP_MUL, 32'h0000_1234, 32'h0000_5678, 32'h0626_0060);
        add_row(exec_pkg::OP_MULHU, 32'h8000_0000, 32'd4, 32'h0000_0002);
        add_row(exec_pkg::OP_MUL, 32'hffff_ffff, 32'd3, 32'hffff_fffd);
        add_row(exec_pkg::OP_DIVU, 32'd100, 32'd7, 32'd14);
        add_row(exec_pkg::OP_REMU, 32'd100, 32'd7, 32'd2);
        add_row(exec_pkg::OP_DIVU, 32'h1234_5678, 32'd0, 32'hffff_ffff);
        add_row(exec_pkg::OP_REMU, 32'h1234_5678, 32'd0, 32'h1234_5678);
        add_row(exec_pkg::OP_DIVU, 32'hffff_ffff, 32'h10, 32'h0fff_ffff);
        // Issued right behind the divide, must overtake it
        add_row(exec_pkg::OP_ADD, 32'd1, 32'd1, 32'd2);
        add_row(exec_pkg::OP_REMU, 32'hffff_ffff, 32'h10, 32'h0000_000f);
        for (int i = 0; i < 2; i++) begin
            a = $urandom;
            b = $urandom;
            add_row(exec_pkg::OP_ADD, a, b, a + b);
            a = $urandom;
            b = $urandom;
            add_row(exec_pkg::OP_XOR, a, b, a ^ b);
        end
    endtask

    ////////////////////
    // Issue side

    // Holds off the issue until the row's ID has been written back
    task automatic wait_id_free(input exec_pkg::id_t id);
        int waited;
        waited = 0;
        while (outstanding[id]) begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
                fail_run("Timeout waiting for an ID to be written back");
            @(negedge clk);
            issue_valid = 1'b0;
            #(HALF_PERIOD / 2);
        end
    endtask

    task automatic issue_row(input int row);
        int waited;
        exec_pkg::id_t id;
        waited = 0;
        id = exec_pkg::id_t'(row % NUM_IDS);
        @(negedge clk);
        issue_valid = 1'b1;
        issue_op = tbl_op[row];
        issue_rs1 = tbl_rs1[row];
        issue_rs2 = tbl_rs2[row];
        issue_id = id;
        #(HALF_PERIOD / 2);
        while (!issue_ready) begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
                fail_run("Timeout waiting for issue_ready");
            @(negedge clk);
            #(HALF_PERIOD / 2);
        end
        // Accepted on this edge
        @(posedge clk);
        row_of_id[id] = row;
        outstanding[id] = 1'b1;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (num_done < NUM_ROWS) begin
            waited++;
            if (waited > TIMEOUT_CYCLES)
                fail_run("Timeout waiting for all results to be written back");
            @(posedge clk);
        end
    endtask

    ////////////////////
    // Writeback monitor

    always @(negedge clk) begin : result_monitor
        int row;
        if (!reset && wb_valid) begin
            if (!outstanding[wb_id])
                fail_run("Writeback seen for an ID with no operation outstanding");
            row = row_of_id[wb_id];
            check_id("wb_id", wb_id, oldest_pending_id(unit_of_op(tbl_op[row])));
            check_data("wb_data", wb_data, tbl_exp[row]);
            done_order[row] = num_done;
            outstanding[wb_id] = 1'b0;
            num_done++;
        end
    end

    initial begin
        reset = 1'b1;
        issue_valid = 1'b0;
        issue_op = exec_pkg::OP_ADD;
        issue_rs1 = '0;
        issue_rs2 = '0;
        issue_id = '0;
        num_done = 0;
        for (int i = 0; i < NUM_IDS; i++) begin
            outstanding[i] = 1'b0;
            row_of_id[i] = 0;
        end
        void'($urandom(32'ha674_20bb));
        build_table();

        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        #(HALF_PERIOD / 2);
        check_flag("wb_valid", wb_valid, 1'b0);
        check_flag("issue_ready", issue_ready, 1'b1);

        for (int r = 0; r < NUM_ROWS; r++) begin
            wait_id_free(exec_pkg::id_t'(r % NUM_IDS));
            issue_row(r);
        end
        @(negedge clk);
        issue_valid = 1'b0;

        wait_drain();
        // Quiet period to catch stray writebacks
        repeat (5) @(posedge clk);

        // ALU op behind the DIVU finishes first
        if (done_order[ALU_AFTER_DIVU_ROW] < done_order[DIVU_ROW]) begin
            $display("Test passed");
        end else begin
            fail_run("ALU op issued after a DIVU was written back after it");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
source/exec_pkg.sv
source/alu_unit.sv
source/mul_unit.sv
source/div_unit.sv
source/writeback_arbiter.sv
source/exec_core.sv
dv/exec_core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the exec_core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f \
        --top-module exec_core_tb -o exec_core_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/exec_core_sim 2>&1)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test passed"; then
    exit 0
fi

echo "Pass message not found in simulation output"
exit 1
